// File: verilog/deparser_pkg.sv
package deparser_pkg;

    // stream widths, top-level defaults
    localparam int data_w = 256;
    localparam int tuser_w = 32;
    localparam int keep_w = data_w / 8;
    localparam int ctrl_w = 512;

    localparam int num_actions = 4;
    localparam int containers_per_size = 4;
    localparam int action_w = 16;

    // phv holds 4x16, 4x32 and 4x48 bit containers
    localparam int phv_w = 384;
    localparam int phv_2b_pos = 0;
    localparam int phv_4b_pos = 64;
    localparam int phv_6b_pos = 192;

    localparam int vlan_id_pos = 116;
    localparam int table_depth = 16;
    localparam int table_addr_w = 4;

    // control frame fields
    localparam int ctrl_mod_id_pos = 368;
    localparam int ctrl_flag_pos = 320;
    localparam int ctrl_index_pos = 384;
    localparam logic [15:0] ctrl_flag = 16'hf2f1;
    localparam logic [2:0] deparser_id = 3'd5;

    // type: 0 none, 1 two bytes, 2 four bytes, 3 six bytes
    typedef struct packed {
        logic [3:0] reserved;
        logic [5:0] offset;
        logic [1:0] ctype;
        logic [2:0] index;
        logic       valid;
    } action_t;

    typedef action_t [num_actions-1:0] action_entry_t;

    typedef struct packed {
        logic [47:0] value;
        logic [2:0]  nbytes;
        logic        wr;
    } container_val_t;

    typedef struct packed {
        logic [data_w-1:0]  data;
        logic [keep_w-1:0]  keep;
        logic [tuser_w-1:0] user;
        logic               last;
    } pkt_beat_t;

    typedef struct packed {
        logic [ctrl_w-1:0] data;
        logic              last;
    } ctrl_beat_t;

endpackage

// File: verilog/action_table.sv
`timescale 1ns/10ps

module action_table #(
    parameter int table_depth = 16,
    parameter int num_actions = 4
) (
    input  logic                                   clk,
    input  logic                                   aresetn,
    input  deparser_pkg::ctrl_beat_t               ctrl_beat,
    input  logic                                   ctrl_valid,
    input  logic [deparser_pkg::table_addr_w-1:0]  rd_addr,
    output deparser_pkg::action_entry_t            entry
);

    localparam int entry_w = num_actions * deparser_pkg::action_w;

    typedef enum logic {
        c_idle,
        c_write
    } c_state_t;

    c_state_t   c_state;
    logic [7:0] wr_idx;
    logic       hdr_match;

    // registered write port
    logic                                  wr_en;
    logic [deparser_pkg::table_addr_w-1:0] wr_addr;
    logic [entry_w-1:0]                    wr_data;

    deparser_pkg::action_entry_t mem [table_depth];

    assign hdr_match = ctrl_valid
        && ctrl_beat.data[deparser_pkg::ctrl_mod_id_pos +: 3] == deparser_pkg::deparser_id
        && ctrl_beat.data[deparser_pkg::ctrl_flag_pos +: 16] == deparser_pkg::ctrl_flag;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            c_state <= c_idle;
            wr_idx <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (c_state)
                c_idle: begin
                    // header beat only loads the start index
                    if (hdr_match && !ctrl_beat.last) begin
                        wr_idx <= ctrl_beat.data[deparser_pkg::ctrl_index_pos +: 8];
                        c_state <= c_write;
                    end
                end
                c_write: begin
                    if (ctrl_valid) begin
                        wr_en <= 1'b1;
                        wr_idx <= wr_idx + 8'd1;
                        if (ctrl_beat.last) begin
                            c_state <= c_idle;
                        end
                    end
                end
                default: c_state <= c_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (c_state == c_write && ctrl_valid) begin
            wr_addr <= wr_idx[deparser_pkg::table_addr_w-1:0];
            wr_data <= ctrl_beat.data[entry_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        entry <= mem[rd_addr];
    end

    // frame must not run past the last entry
    assert property (@(posedge clk) disable iff (!aresetn)
        (c_state == c_write && ctrl_valid) |-> wr_idx < table_depth);

endmodule

// File: verilog/container_extract.sv
`timescale 1ns/10ps

module container_extract #(
    parameter int containers_per_size = 4
) (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic                             start,
    input  deparser_pkg::action_t            action,
    input  logic [deparser_pkg::phv_w-1:0]   phv,
    output deparser_pkg::container_val_t     value
);

    logic [47:0] sel;
    logic [2:0]  sel_bytes;
    logic [47:0] val_q;
    logic [2:0]  nbytes_q;
    logic        wr_q;

    // first byte of the container lands in lane 0
    function automatic logic [47:0] swap_bytes(input logic [47:0] c, input int n);
        logic [47:0] r;
        r = '0;
        for (int k = 0; k < 6; k++) begin
            if (k < n) begin
                r[k*8 +: 8] = c[(n-1-k)*8 +: 8];
            end
        end
        return r;
    endfunction

    always_comb begin
        sel = '0;
        sel_bytes = 3'd0;
        if (action.valid && action.index < containers_per_size) begin
            case (action.ctype)
                2'd1: begin
                    sel[15:0] = phv[deparser_pkg::phv_2b_pos + action.index*16 +: 16];
                    sel_bytes = 3'd2;
                end
                2'd2: begin
                    sel[31:0] = phv[deparser_pkg::phv_4b_pos + action.index*32 +: 32];
                    sel_bytes = 3'd4;
                end
                2'd3: begin
                    sel = phv[deparser_pkg::phv_6b_pos + action.index*48 +: 48];
                    sel_bytes = 3'd6;
                end
                default: sel_bytes = 3'd0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wr_q <= 1'b0;
        end else if (start) begin
            wr_q <= sel_bytes != 3'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            val_q <= swap_bytes(sel, int'(sel_bytes));
            nbytes_q <= sel_bytes;
        end
    end

    assign value = '{value: val_q, nbytes: nbytes_q, wr: wr_q};

    assert property (@(posedge clk) disable iff (!aresetn)
        (start && action.valid) |-> action.index < containers_per_size);

endmodule

// File: verilog/header_rewrite.sv
`timescale 1ns/10ps

module header_rewrite #(
    parameter int data_w = 256,
    parameter int num_actions = 4
) (
    input  logic [data_w-1:0]              beat_data,
    input  deparser_pkg::container_val_t   values [num_actions],
    input  deparser_pkg::action_entry_t    entry,
    output logic [data_w-1:0]              new_data
);

    localparam int lanes = data_w / 8;

    logic [7:0] beat_bytes [lanes];

    // later actions overwrite earlier ones
    always_comb begin
        for (int b = 0; b < lanes; b++) begin
            beat_bytes[b] = beat_data[b*8 +: 8];
        end
        for (int i = 0; i < num_actions; i++) begin
            if (values[i].wr
                    && int'(entry[i].offset) + int'(values[i].nbytes) <= lanes) begin
                for (int k = 0; k < 6; k++) begin
                    if (k < int'(values[i].nbytes)) begin
                        beat_bytes[int'(entry[i].offset) + k] = values[i].value[k*8 +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < lanes; b++) begin
            new_data[b*8 +: 8] = beat_bytes[b];
        end
    end

endmodule

// File: verilog/deparser_ctrl.sv
`timescale 1ns/10ps

module deparser_ctrl #(
    parameter int data_w = 256,
    parameter int tuser_w = 32
) (
    input  logic                                   clk,
    input  logic                                   aresetn,

    input  deparser_pkg::pkt_beat_t                pkt_beat,
    input  logic                                   pkt_empty,
    output logic                                   pkt_rd_en,

    input  logic [deparser_pkg::phv_w-1:0]         phv,
    input  logic                                   phv_empty,
    output logic                                   phv_rd_en,

    output logic [deparser_pkg::table_addr_w-1:0]  rd_addr,
    output logic                                   extract_start,
    output logic [deparser_pkg::phv_w-1:0]         held_phv,
    output logic [data_w-1:0]                      held_data,
    input  logic [data_w-1:0]                      new_data,

    output deparser_pkg::pkt_beat_t                out_beat,
    output logic                                   out_valid,
    input  logic                                   out_ready
);

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_extract,
        s_apply,
        s_send_hdr,
        s_stream
    } state_t;

    state_t               state;
    logic                 start_pkt;
    logic [data_w/8-1:0]  held_keep;
    logic [tuser_w-1:0]   held_user;
    logic                 held_last;

    assign start_pkt = state == s_idle && !pkt_empty && !phv_empty;

    // both fifos pop together on the first beat
    assign phv_rd_en = start_pkt;
    assign pkt_rd_en = start_pkt || (state == s_stream && out_ready && !pkt_empty);

    assign rd_addr = held_data[deparser_pkg::vlan_id_pos +: deparser_pkg::table_addr_w];
    assign extract_start = state == s_extract;

    // tail beats go straight from the fifo
    assign out_valid = state == s_send_hdr || (state == s_stream && !pkt_empty);
    assign out_beat = (state == s_send_hdr)
        ? '{data: held_data, keep: held_keep, user: held_user, last: held_last}
        : pkt_beat;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (start_pkt) begin
                        state <= s_lookup;
                    end
                end
                s_lookup: state <= s_extract;
                s_extract: state <= s_apply;
                s_apply: state <= s_send_hdr;
                s_send_hdr: begin
                    if (out_ready) begin
                        state <= held_last ? s_idle : s_stream;
                    end
                end
                s_stream: begin
                    if (out_ready && !pkt_empty && pkt_beat.last) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_pkt) begin
            held_data <= pkt_beat.data;
            held_keep <= pkt_beat.keep;
            held_user <= pkt_beat.user;
            held_last <= pkt_beat.last;
            held_phv <= phv;
        end else if (state == s_apply) begin
            held_data <= new_data;
        end
    end

    // a stalled output beat holds until it is taken
    assert property (@(posedge clk) disable iff (!aresetn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)));

endmodule

// File: verilog/deparser.sv
`timescale 1ns/10ps

module deparser #(
    parameter int data_w = deparser_pkg::data_w,
    parameter int tuser_w = deparser_pkg::tuser_w,
    parameter int num_actions = deparser_pkg::num_actions,
    parameter int containers_per_size = deparser_pkg::containers_per_size,
    parameter int table_depth = deparser_pkg::table_depth
) (
    input  logic                            clk,
    input  logic                            aresetn,

    input  deparser_pkg::pkt_beat_t         pkt_beat,
    input  logic                            pkt_empty,
    output logic                            pkt_rd_en,

    input  logic [deparser_pkg::phv_w-1:0]  phv,
    input  logic                            phv_empty,
    output logic                            phv_rd_en,

    input  deparser_pkg::ctrl_beat_t        ctrl_beat,
    input  logic                            ctrl_valid,

    output deparser_pkg::pkt_beat_t         out_beat,
    output logic                            out_valid,
    input  logic                            out_ready
);

    deparser_pkg::action_entry_t           entry;
    logic [deparser_pkg::table_addr_w-1:0] rd_addr;
    logic                                  extract_start;
    logic [deparser_pkg::phv_w-1:0]        held_phv;
    logic [data_w-1:0]                     held_data;
    logic [data_w-1:0]                     new_data;
    deparser_pkg::container_val_t          values [num_actions];

    action_table #(
        .table_depth (table_depth),
        .num_actions (num_actions)
    ) action_table_i (
        .clk        (clk),
        .aresetn    (aresetn),
        .ctrl_beat  (ctrl_beat),
        .ctrl_valid (ctrl_valid),
        .rd_addr    (rd_addr),
        .entry      (entry)
    );

    deparser_ctrl #(
        .data_w  (data_w),
        .tuser_w (tuser_w)
    ) deparser_ctrl_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .pkt_beat      (pkt_beat),
        .pkt_empty     (pkt_empty),
        .pkt_rd_en     (pkt_rd_en),
        .phv           (phv),
        .phv_empty     (phv_empty),
        .phv_rd_en     (phv_rd_en),
        .rd_addr       (rd_addr),
        .extract_start (extract_start),
        .held_phv      (held_phv),
        .held_data     (held_data),
        .new_data      (new_data),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

    // one extractor per action slot
    for (genvar i = 0; i < num_actions; i++) begin : gen_extract
        container_extract #(
            .containers_per_size (containers_per_size)
        ) container_extract_i (
            .clk     (clk),
            .aresetn (aresetn),
            .start   (extract_start),
            .action  (entry[i]),
            .phv     (held_phv),
            .value   (values[i])
        );
    end

    header_rewrite #(
        .data_w      (data_w),
        .num_actions (num_actions)
    ) header_rewrite_i (
        .beat_data (held_data),
        .values    (values),
        .entry     (entry),
        .new_data  (new_data)
    );

endmodule

// File: sim/deparser_tb.sv
`timescale 1ns/10ps

module deparser_tb;

    typedef struct packed {
        logic [3:0]   idx;
        logic [63:0]  actions;
        logic [383:0] phv;
        logic [3:0]   nbeats;
        logic [7:0]   pattern;
        logic [4:0]   chk_off;
        logic [15:0]  chk_val;
        logic         force_rdy;
        logic         bad_ctrl;
    } row_t;

    logic clk = 1'b0;
    logic aresetn;
    deparser_pkg::pkt_beat_t  pkt_beat;
    logic                     pkt_empty;
    logic                     pkt_rd_en;
    logic [383:0]             phv;
    logic                     phv_empty;
    logic                     phv_rd_en;
    deparser_pkg::ctrl_beat_t ctrl_beat;
    logic                     ctrl_valid;
    deparser_pkg::pkt_beat_t  out_beat;
    logic                     out_valid;
    logic                     out_ready;

    deparser_pkg::pkt_beat_t pkt_q[$];
    deparser_pkg::pkt_beat_t exp_q[$];
    logic [383:0]            phv_q[$];
    int                      chk_off_q[$];
    logic [15:0]             chk_val_q[$];
    logic [63:0]             tbl_model [16];
    row_t                    rows [6];
    logic [31:0]             rng = 32'h438d;
    logic                    force_ready = 1'b1;

    deparser deparser_i (
        .clk        (clk),
        .aresetn    (aresetn),
        .pkt_beat   (pkt_beat),
        .pkt_empty  (pkt_empty),
        .pkt_rd_en  (pkt_rd_en),
        .phv        (phv),
        .phv_empty  (phv_empty),
        .phv_rd_en  (phv_rd_en),
        .ctrl_beat  (ctrl_beat),
        .ctrl_valid (ctrl_valid),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] act(input logic v, input logic [2:0] idx,
                                        input logic [1:0] ctype, input logic [5:0] off);
        return {4'h0, off, ctype, idx, v};
    endfunction

    // action 0 in the low word
    function automatic logic [63:0] entry_of(input logic [15:0] a0, input logic [15:0] a1,
                                             input logic [15:0] a2, input logic [15:0] a3);
        return {a3, a2, a1, a0};
    endfunction

    function automatic logic [383:0] make_phv(input logic [7:0] s);
        logic [383:0] p;
        for (int j = 0; j < 48; j++) begin
            p[j*8 +: 8] = s + 8'(j);
        end
        return p;
    endfunction

    function automatic logic [255:0] beat_data(input logic [7:0] pattern, input int beat);
        logic [255:0] d;
        for (int b = 0; b < 32; b++) begin
            d[b*8 +: 8] = pattern + 8'(beat * 32 + b);
        end
        return d;
    endfunction

    // container i of size n starts at group base + i*n bytes, big-endian in the phv
    function automatic logic [255:0] model_rewrite(input logic [255:0] d,
                                                   input logic [63:0] ent,
                                                   input logic [383:0] p);
        logic [15:0] a;
        logic [47:0] c;
        int          n;
        int          off;
        int          base;
        for (int i = 0; i < 4; i++) begin
            a = ent[i*16 +: 16];
            n = 2 * int'(a[5:4]);
            off = int'(a[11:6]);
            if (a[0] && n != 0 && off + n <= 32) begin
                base = (n == 2) ? 0 : (n == 4) ? 64 : 192;
                c = p[base + int'(a[3:1]) * n * 8 +: 48];
                for (int k = 0; k < n; k++) begin
                    d[(off + k)*8 +: 8] = c[(n - 1 - k)*8 +: 8];
                end
            end
        end
        return d;
    endfunction

    function automatic row_t make_row(input logic [3:0] idx, input logic [63:0] actions,
                                      input logic [7:0] phv_seed, input logic [3:0] nbeats,
                                      input logic [7:0] pattern, input logic [4:0] chk_off,
                                      input logic [15:0] chk_val, input logic force_rdy,
                                      input logic bad_ctrl);
        row_t r;
        r.idx = idx;
        r.actions = actions;
        r.phv = make_phv(phv_seed);
        r.nbeats = nbeats;
        r.pattern = pattern;
        r.chk_off = chk_off;
        r.chk_val = chk_val;
        r.force_rdy = force_rdy;
        r.bad_ctrl = bad_ctrl;
        return r;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run("output value mismatch");
        end
    endtask

    task automatic check_out_beat();
        if (exp_q.size() == 0) begin
            fail_run("an output beat appeared while no packet was pending");
        end else begin
            check_value("out_beat.data", out_beat.data, exp_q[0].data);
            check_value("out_beat.keep", out_beat.keep, exp_q[0].keep);
            check_value("out_beat.user", out_beat.user, exp_q[0].user);
            check_value("out_beat.last", out_beat.last, exp_q[0].last);
            if (chk_off_q[0] >= 0) begin
                check_value("header bytes", out_beat.data[chk_off_q[0]*8 +: 16], chk_val_q[0]);
            end
            void'(exp_q.pop_front());
            void'(chk_off_q.pop_front());
            void'(chk_val_q.pop_front());
        end
    endtask

    // fifo models and output monitor, sampled at the falling edge
    initial begin
        logic pop_pkt;
        logic pop_phv;
        forever begin
            @(negedge clk);
            pop_pkt = aresetn && pkt_rd_en && !pkt_empty;
            pop_phv = aresetn && phv_rd_en && !phv_empty;
            if (aresetn && out_valid && out_ready) begin
                check_out_beat();
            end
            @(posedge clk);
            #1;
            if (pop_pkt) begin
                void'(pkt_q.pop_front());
            end
            if (pop_phv) begin
                void'(phv_q.pop_front());
            end
            pkt_empty = pkt_q.size() == 0;
            pkt_beat = pkt_empty ? '0 : pkt_q[0];
            phv_empty = phv_q.size() == 0;
            phv = phv_empty ? '0 : phv_q[0];
            rng = xorshift(rng);
            out_ready = force_ready || rng[7];
        end
    end

    // header beat with module id, flag and start index, then one entry beat
    task automatic send_ctrl(input logic [2:0] id, input logic [15:0] flag,
                             input logic [3:0] idx, input logic [63:0] ent);
        deparser_pkg::ctrl_beat_t hdr;
        deparser_pkg::ctrl_beat_t body;
        hdr = '0;
        hdr.data[deparser_pkg::ctrl_mod_id_pos +: 8] = {5'h00, id};
        hdr.data[deparser_pkg::ctrl_flag_pos +: 16] = flag;
        hdr.data[deparser_pkg::ctrl_index_pos +: 8] = {4'h0, idx};
        body = '0;
        body.data[63:0] = ent;
        body.last = 1'b1;
        @(posedge clk);
        #1;
        ctrl_beat = hdr;
        ctrl_valid = 1'b1;
        @(posedge clk);
        #1;
        ctrl_beat = body;
        @(posedge clk);
        #1;
        ctrl_valid = 1'b0;
        ctrl_beat = '0;
    endtask

    task automatic send_packet(input row_t r);
        deparser_pkg::pkt_beat_t b;
        for (int i = 0; i < int'(r.nbeats); i++) begin
            b.data = beat_data(r.pattern, i);
            if (i == 0) begin
                b.data[deparser_pkg::vlan_id_pos +: 12] = {8'h00, r.idx};
            end
            b.last = i == int'(r.nbeats) - 1;
            b.keep = b.last ? 32'h00ff_ffff : '1;
            b.user = {r.pattern, 16'h0000, 8'(i)};
            pkt_q.push_back(b);
            if (i == 0) begin
                b.data = model_rewrite(b.data, tbl_model[r.idx], r.phv);
            end
            exp_q.push_back(b);
            chk_off_q.push_back((i == 0) ? int'(r.chk_off) : -1);
            chk_val_q.push_back(r.chk_val);
        end
        phv_q.push_back(r.phv);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || pkt_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 1000) begin
                fail_run("timeout waiting for the packet to leave the deparser");
            end
        end
    endtask

    initial begin
        aresetn = 1'b0;
        pkt_beat = '0;
        pkt_empty = 1'b1;
        phv = '0;
        phv_empty = 1'b1;
        ctrl_beat = '0;
        ctrl_valid = 1'b0;
        out_ready = 1'b0;
        rows[0] = make_row(4'd3, entry_of(act(1, 1, 1, 0), act(1, 2, 2, 4), act(1, 0, 3, 8),
                           act(1, 3, 1, 20)), 8'h10, 4'd1, 8'h01, 5'd20, 16'h1617, 1, 0);
        rows[1] = make_row(4'd5, entry_of(act(1, 3, 3, 26), act(0, 0, 1, 0), act(0, 1, 2, 2),
                           act(0, 2, 3, 4)), 8'h40, 4'd3, 8'h90, 5'd26, 16'h6e6f, 1, 0);
        // invalid, type 0 and out of range actions
        rows[2] = make_row(4'd7, entry_of(act(0, 1, 2, 0), act(1, 0, 0, 2), act(1, 0, 2, 30),
                           act(1, 1, 3, 28)), 8'h80, 4'd2, 8'h20, 5'd0, 16'h2120, 0, 0);
        // overlap on lanes 6 and 7
        rows[3] = make_row(4'd9, entry_of(act(1, 1, 2, 4), act(1, 2, 1, 6), act(0, 0, 0, 0),
                           act(0, 0, 0, 0)), 8'hc0, 4'd4, 8'h33, 5'd6, 16'hc4c5, 0, 0);
        // rejected frames aimed at entry 3
        rows[4] = make_row(4'd3, entry_of(act(1, 0, 1, 0), act(1, 0, 1, 0), act(1, 0, 1, 0),
                           act(1, 0, 1, 0)), 8'h10, 4'd2, 8'h55, 5'd20, 16'h1617, 0, 1);
        rows[5] = make_row(4'd12, entry_of(act(1, 2, 3, 0), act(1, 3, 2, 28), act(1, 0, 1, 31),
                           act(0, 0, 0, 0)), 8'h33, 4'd5, 8'hd0, 5'd0, 16'h5b5c, 0, 0);

        repeat (8) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            check_value("pkt_rd_en", pkt_rd_en, 0);
            check_value("phv_rd_en", phv_rd_en, 0);
        end
        @(posedge clk);
        #1;
        aresetn = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            check_value("pkt_rd_en", pkt_rd_en, 0);
            check_value("phv_rd_en", phv_rd_en, 0);
        end

        for (int r = 0; r < 6; r++) begin
            if (rows[r].bad_ctrl) begin
                send_ctrl(3'd4, deparser_pkg::ctrl_flag, rows[r].idx, rows[r].actions);
                send_ctrl(deparser_pkg::deparser_id, 16'hf2f0, rows[r].idx, rows[r].actions);
            end else begin
                send_ctrl(deparser_pkg::deparser_id, deparser_pkg::ctrl_flag, rows[r].idx,
                          rows[r].actions);
                tbl_model[rows[r].idx] = rows[r].actions;
            end
            repeat (2) @(posedge clk);
            #5;
            force_ready = rows[r].force_rdy;
            send_packet(rows[r]);
            wait_drained();
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: sources.f
verilog/deparser_pkg.sv
verilog/action_table.sv
verilog/container_extract.sv
verilog/header_rewrite.sv
verilog/deparser_ctrl.sv
verilog/deparser.sv
sim/deparser_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the deparser testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module deparser_tb -o deparser_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/deparser_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi

exit 0
